//--- Makefile
# Verilator build for the first conv layer testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_cnn_conv_top
FILELIST  ?= cnn_conv_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test completed successfully

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# pass only when the pass message shows up as a line of its own
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- cnn_conv_top.f
+incdir+common
common/cnn_pkg.sv
rtl/cnn_ctrl.sv
conv_engine/line_window.sv
conv_engine/conv_array.sv
rtl/result_fifo.sv
rtl/result_serializer.sv
rtl/cnn_conv_top.sv
tb/tb_cnn_conv_top.sv

//--- common/cnn_pkg.sv
`include "cnn_settings.svh"

package cnn_pkg;

    typedef logic signed [`CNN_PIXEL_W-1:0] pixel_t;
    typedef logic signed [`CNN_PIXEL_W-1:0] conv_sum_t;   // wraps modulo 2^32

    // element 0 is the oldest pixel (top-left), last one the newest (bottom-right)
    typedef pixel_t [`CNN_KERNEL*`CNN_KERNEL-1:0] window_t;

    // bit k of channel c weights window element k
    typedef logic [`CNN_CHANNELS-1:0][`CNN_KERNEL*`CNN_KERNEL-1:0] weight_set_t;

    // one sum per channel for a single window position
    typedef struct packed {
        conv_sum_t [`CNN_CHANNELS-1:0] sum;
    } conv_group_t;

    typedef logic [2:0] channel_t;

    typedef enum logic [1:0] {
        PH_IDLE    = 2'd0,
        PH_WEIGHTS = 2'd1,
        PH_IMAGE   = 2'd2,
        PH_DRAIN   = 2'd3
    } cnn_phase_t;

endpackage

//--- common/cnn_settings.svh
`ifndef CNN_SETTINGS_SVH
`define CNN_SETTINGS_SVH

// image side in pixels
`define CNN_IMG_SIZE    28
// sliding window side
`define CNN_KERNEL      5
// output channels of the first conv layer
`define CNN_CHANNELS    6
// pixel and channel sum width
`define CNN_PIXEL_W     32
// result groups held between conv engine and serializer
`define CNN_FIFO_DEPTH  8

`endif

//--- conv_engine/conv_array.sv
`timescale 1ns/1ps
`include "cnn_settings.svh"

module conv_array (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 weight_take,
    input  logic                 weight_bit,
    input  logic                 win_valid,
    input  cnn_pkg::window_t     win,
    output logic                 group_valid,
    output cnn_pkg::conv_group_t group
);
    import cnn_pkg::*;

    localparam int CH   = `CNN_CHANNELS;
    localparam int TAPS = `CNN_KERNEL * `CNN_KERNEL;

    weight_set_t weights;
    conv_sum_t   sum_d [CH];

    // shift right from the top, so after a full load the first bit sits in
    // channel 0 element 0 and global bit n lands at flat position n
    always_ff @(posedge clk) begin
        if (weight_take) begin
            weights <= {weight_bit, weights[CH-1:1], weights[0][TAPS-1:1]};
        end
    end

    for (genvar c = 0; c < CH; c++) begin : g_chan
        always_comb begin
            sum_d[c] = '0;
            for (int k = 0; k < TAPS; k++) begin
                if (weights[c][k]) begin
                    sum_d[c] = sum_d[c] + win[k];   // weight bit 1
                end else begin
                    sum_d[c] = sum_d[c] - win[k];   // weight bit 0
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            group_valid <= 1'b0;
        end else begin
            group_valid <= win_valid;
        end
    end

    // one group per window position
    always_ff @(posedge clk) begin
        if (win_valid) begin
            for (int c = 0; c < CH; c++) begin
                group.sum[c] <= sum_d[c];
            end
        end
    end

endmodule

//--- conv_engine/line_window.sv
`timescale 1ns/1ps
`include "cnn_settings.svh"

module line_window (
    input  logic             clk,
    input  logic             rstn,
    input  logic             pixel_take,
    input  cnn_pkg::pixel_t  pixel,
    output logic             win_valid,
    output cnn_pkg::window_t win
);
    import cnn_pkg::*;

    localparam int IMG = `CNN_IMG_SIZE;
    localparam int K   = `CNN_KERNEL;
    localparam int CW  = $clog2(IMG);

    // row_buf[0] holds the oldest line, row_buf[K-2] the line just above
    pixel_t        row_buf [K-1][IMG];
    pixel_t        new_col [K];         // column entering the window, top first
    logic [CW-1:0] col;
    logic [CW-1:0] row;

    always_comb begin
        for (int r = 0; r < K - 1; r++) begin
            new_col[r] = row_buf[r][col];
        end
        new_col[K-1] = pixel;
    end

    // each line moves up one buffer at the current column
    always_ff @(posedge clk) begin
        if (pixel_take) begin
            for (int r = 0; r < K - 1; r++) begin
                row_buf[r][col] <= new_col[r+1];
            end
        end
    end

    // window slides left, new column on the right
    always_ff @(posedge clk) begin
        if (pixel_take) begin
            for (int r = 0; r < K; r++) begin
                for (int c = 0; c < K - 1; c++) begin
                    win[r*K+c] <= win[r*K+c+1];
                end
                win[r*K+K-1] <= new_col[r];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            col       <= '0;
            row       <= '0;
            win_valid <= 1'b0;
        end else begin
            // window lies fully inside the image only from row 4, col 4 on
            win_valid <= pixel_take && (row >= CW'(K - 1)) && (col >= CW'(K - 1));
            if (pixel_take) begin
                if (col == CW'(IMG - 1)) begin
                    col <= '0;
                    if (row == CW'(IMG - 1)) begin
                        row <= '0;   // ready for the next image
                    end else begin
                        row <= row + 1'b1;
                    end
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

endmodule

//--- rtl/cnn_conv_top.sv
`timescale 1ns/1ps

module cnn_conv_top (
    input  logic               clk,
    input  logic               rstn,
    input  logic               start,
    input  logic               weight_tvalid,
    input  logic               weight_tdata,
    output logic               weight_tready,
    input  logic               image_tvalid,
    input  cnn_pkg::pixel_t    image_tdata,
    output logic               image_tready,
    output logic               result_tvalid,
    output cnn_pkg::conv_sum_t result_tdata,
    output cnn_pkg::channel_t  result_channel,
    output logic               cnn_done
);
    import cnn_pkg::*;

    logic        pixel_take;
    logic        weight_take;
    logic        win_valid;
    window_t     win;
    logic        group_valid;
    conv_group_t group;
    logic        fifo_empty;
    logic        fifo_almost_full;
    conv_group_t head;
    logic        pop;
    logic        ser_idle;

    cnn_ctrl i_cnn_ctrl (
        .clk              (clk),
        .rstn             (rstn),
        .start            (start),
        .image_tvalid     (image_tvalid),
        .weight_tvalid    (weight_tvalid),
        .fifo_almost_full (fifo_almost_full),
        .fifo_empty       (fifo_empty),
        .ser_idle         (ser_idle),
        .image_tready     (image_tready),
        .weight_tready    (weight_tready),
        .pixel_take       (pixel_take),
        .weight_take      (weight_take),
        .cnn_done         (cnn_done)
    );

    line_window i_line_window (
        .clk        (clk),
        .rstn       (rstn),
        .pixel_take (pixel_take),
        .pixel      (image_tdata),
        .win_valid  (win_valid),
        .win        (win)
    );

    conv_array i_conv_array (
        .clk         (clk),
        .rstn        (rstn),
        .weight_take (weight_take),
        .weight_bit  (weight_tdata),
        .win_valid   (win_valid),
        .win         (win),
        .group_valid (group_valid),
        .group       (group)
    );

    result_fifo i_result_fifo (
        .clk              (clk),
        .rstn             (rstn),
        .push             (group_valid),
        .din              (group),
        .pop              (pop),
        .head             (head),
        .fifo_empty       (fifo_empty),
        .fifo_almost_full (fifo_almost_full)
    );

    result_serializer i_result_serializer (
        .clk            (clk),
        .rstn           (rstn),
        .fifo_empty     (fifo_empty),
        .head           (head),
        .pop            (pop),
        .ser_idle       (ser_idle),
        .result_tvalid  (result_tvalid),
        .result_tdata   (result_tdata),
        .result_channel (result_channel)
    );

endmodule

//--- rtl/cnn_ctrl.sv
`timescale 1ns/1ps
`include "cnn_settings.svh"

module cnn_ctrl (
    input  logic clk,
    input  logic rstn,
    input  logic start,
    input  logic image_tvalid,
    input  logic weight_tvalid,
    input  logic fifo_almost_full,
    input  logic fifo_empty,
    input  logic ser_idle,
    output logic image_tready,
    output logic weight_tready,
    output logic pixel_take,
    output logic weight_take,
    output logic cnn_done
);
    import cnn_pkg::*;

    localparam int N_WEIGHTS = `CNN_CHANNELS * `CNN_KERNEL * `CNN_KERNEL;
    localparam int N_PIXELS  = `CNN_IMG_SIZE * `CNN_IMG_SIZE;
    localparam int WCW       = $clog2(N_WEIGHTS + 1);
    localparam int PCW       = $clog2(N_PIXELS + 1);

    cnn_phase_t     phase;
    logic           start_d;
    logic           start_edge;
    logic [WCW-1:0] weight_cnt;
    logic [PCW-1:0] pixel_cnt;
    logic [1:0]     drain_cnt;   // covers the two-stage conv pipeline

    assign start_edge   = start && !start_d;
    assign weight_take  = weight_tvalid && weight_tready;
    // stall the image while the fifo cannot absorb groups still in flight
    assign image_tready = (phase == PH_IMAGE) && !fifo_almost_full;
    assign pixel_take   = image_tvalid && image_tready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            start_d       <= 1'b0;
            phase         <= PH_IDLE;
            weight_tready <= 1'b0;
            weight_cnt    <= '0;
            pixel_cnt     <= '0;
            drain_cnt     <= '0;
            cnn_done      <= 1'b0;
        end else begin
            start_d  <= start;
            cnn_done <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (start_edge) begin   // edges while busy fall through here
                        phase         <= PH_WEIGHTS;
                        weight_tready <= 1'b1;
                        weight_cnt    <= '0;
                        pixel_cnt     <= '0;
                    end
                end
                PH_WEIGHTS: begin
                    if (weight_take) begin
                        weight_cnt <= weight_cnt + 1'b1;
                        if (weight_cnt == WCW'(N_WEIGHTS - 1)) begin
                            weight_tready <= 1'b0;
                            phase         <= PH_IMAGE;
                        end
                    end
                end
                PH_IMAGE: begin
                    if (pixel_take) begin
                        pixel_cnt <= pixel_cnt + 1'b1;
                        if (pixel_cnt == PCW'(N_PIXELS - 1)) begin
                            phase     <= PH_DRAIN;
                            drain_cnt <= '0;
                        end
                    end
                end
                PH_DRAIN: begin
                    if (drain_cnt != 2'd3) begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end else if (fifo_empty && ser_idle) begin
                        cnn_done <= 1'b1;
                        phase    <= PH_IDLE;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/result_fifo.sv
`timescale 1ns/1ps
`include "cnn_settings.svh"

module result_fifo (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 push,
    input  cnn_pkg::conv_group_t din,
    input  logic                 pop,
    output cnn_pkg::conv_group_t head,
    output logic                 fifo_empty,
    output logic                 fifo_almost_full
);
    import cnn_pkg::*;

    localparam int DEPTH = `CNN_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    conv_group_t   mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          wr_en;
    logic          rd_en;

    assign wr_en      = push && (count != (AW + 1)'(DEPTH));
    assign rd_en      = pop && !fifo_empty;
    assign head       = mem[rd_ptr];
    assign fifo_empty = (count == '0);
    // fewer than three free slots, two groups may still be in the conv pipeline
    assign fifo_almost_full = (count > (AW + 1)'(DEPTH - 3));

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // none or both
            endcase
        end
    end

endmodule

//--- rtl/result_serializer.sv
`timescale 1ns/1ps
`include "cnn_settings.svh"

module result_serializer (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 fifo_empty,
    input  cnn_pkg::conv_group_t head,
    output logic                 pop,
    output logic                 ser_idle,
    output logic                 result_tvalid,
    output cnn_pkg::conv_sum_t   result_tdata,
    output cnn_pkg::channel_t    result_channel
);
    import cnn_pkg::*;

    localparam channel_t LAST_CH = channel_t'(`CNN_CHANNELS - 1);

    conv_group_t grp;    // group being streamed
    channel_t    ch;     // next channel to send
    logic        busy;

    // next pop lands in the cycle channel 5 shows on the output
    assign pop      = !busy && !fifo_empty;
    assign ser_idle = !busy;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy          <= 1'b0;
            ch            <= '0;
            result_tvalid <= 1'b0;
        end else begin
            result_tvalid <= pop || busy;
            if (pop) begin
                busy <= 1'b1;
                ch   <= channel_t'(1);   // channel 0 goes out with the pop
            end else if (busy) begin
                if (ch == LAST_CH) begin
                    busy <= 1'b0;
                end
                ch <= ch + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            grp            <= head;
            result_tdata   <= head.sum[0];
            result_channel <= '0;
        end else if (busy) begin
            result_tdata   <= grp.sum[ch];
            result_channel <= ch;
        end
    end

endmodule

//--- tb/tb_cnn_conv_top.sv
`timescale 1ns/1ps
`include "cnn_settings.svh"

module tb_cnn_conv_top;
    import cnn_pkg::*;

    localparam int IMG     = `CNN_IMG_SIZE;
    localparam int K       = `CNN_KERNEL;
    localparam int CH      = `CNN_CHANNELS;
    localparam int TAPS    = K * K;
    localparam int OUT     = IMG - K + 1;
    localparam int N_ROWS  = 4;
    localparam int RESULTS = OUT * OUT * CH;
    // weights, stalled pixels, serialized results and drain slack per case
    localparam int WATCHDOG_CYCLES = N_ROWS * (150 + 784 * 8 + 576 * 6 + 200);

    localparam logic [1:0] W_ONES  = 2'd0;
    localparam logic [1:0] W_ZEROS = 2'd1;
    localparam logic [1:0] W_ALT   = 2'd2;   // 1 on even window elements
    localparam logic [1:0] W_RAND  = 2'd3;

    typedef struct packed {
        logic               rand_img;   // random 8-bit pixels instead of a constant
        pixel_t             value;
        logic [CH-1:0][1:0] wkind;
        logic [6:0]         gap_pct;    // chance in percent of an idle valid cycle
        conv_sum_t [CH-1:0] exp_sum;    // constant images only
    } case_row_t;

    typedef struct packed {
        channel_t  ch;
        conv_sum_t sum;
    } exp_word_t;

    logic      clk;
    logic      rstn;
    logic      start;
    logic      weight_tvalid;
    logic      weight_tdata;
    logic      weight_tready;
    logic      image_tvalid;
    pixel_t    image_tdata;
    logic      image_tready;
    logic      result_tvalid;
    conv_sum_t result_tdata;
    channel_t  result_channel;
    logic      cnn_done;

    case_row_t          cases [N_ROWS];
    logic [CH*TAPS-1:0] wbits;
    pixel_t             img [IMG*IMG];
    exp_word_t          exp_q [$];
    int                 result_cnt;
    int                 done_cnt;

    cnn_conv_top i_cnn_conv_top (
        .clk            (clk),
        .rstn           (rstn),
        .start          (start),
        .weight_tvalid  (weight_tvalid),
        .weight_tdata   (weight_tdata),
        .weight_tready  (weight_tready),
        .image_tvalid   (image_tvalid),
        .image_tdata    (image_tdata),
        .image_tready   (image_tready),
        .result_tvalid  (result_tvalid),
        .result_tdata   (result_tdata),
        .result_channel (result_channel),
        .cnn_done       (cnn_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: actual 0x%08h, expected 0x%08h", name, actual, expected);
            abort_run("value mismatch");
        end
    endtask

    // channel 5 first in each concatenation
    task automatic load_cases();
        cases[0] = '{rand_img: 1'b0, value: 32'sd3,
                     wkind: {W_ALT, W_ZEROS, W_ONES, W_ALT, W_ZEROS, W_ONES},
                     gap_pct: 7'd0,
                     exp_sum: {32'sd3, -32'sd75, 32'sd75, 32'sd3, -32'sd75, 32'sd75}};
        cases[1] = '{rand_img: 1'b0, value: -32'sd7,
                     wkind: {W_ALT, W_ONES, W_ZEROS, W_ONES, W_ALT, W_ZEROS},
                     gap_pct: 7'd30,
                     exp_sum: {-32'sd7, -32'sd175, 32'sd175, -32'sd175, -32'sd7, 32'sd175}};
        cases[2] = '{rand_img: 1'b1, value: '0,
                     wkind: {W_RAND, W_RAND, W_RAND, W_RAND, W_RAND, W_RAND},
                     gap_pct: 7'd0, exp_sum: '0};
        cases[3] = '{rand_img: 1'b1, value: '0,
                     wkind: {W_RAND, W_ZEROS, W_RAND, W_ALT, W_ONES, W_RAND},
                     gap_pct: 7'd40, exp_sum: '0};
    endtask

    // weight bits, image and expected results for one case
    task automatic build_case(input int row);
        case_row_t c;
        exp_word_t e;
        int        acc;
        int        pix;
        c = cases[row];
        for (int n = 0; n < CH * TAPS; n++) begin
            case (c.wkind[n / TAPS])
                W_ONES:  wbits[n] = 1'b1;
                W_ZEROS: wbits[n] = 1'b0;
                W_ALT:   wbits[n] = ((n % TAPS) % 2 == 0);
                default: wbits[n] = 1'($urandom_range(1));
            endcase
        end
        for (int p = 0; p < IMG * IMG; p++) begin
            img[p] = c.rand_img ? pixel_t'(int'($urandom_range(255)) - 128) : c.value;
        end
        for (int r = 0; r < OUT; r++) begin
            for (int col = 0; col < OUT; col++) begin
                for (int ch = 0; ch < CH; ch++) begin
                    acc = 0;
                    for (int k = 0; k < TAPS; k++) begin
                        pix = img[(r + k / K) * IMG + col + k % K];
                        acc = wbits[ch * TAPS + k] ? acc + pix : acc - pix;
                    end
                    e.ch  = channel_t'(ch);
                    e.sum = c.rand_img ? conv_sum_t'(acc) : c.exp_sum[ch];
                    exp_q.push_back(e);
                end
            end
        end
    endtask

    task automatic send_weights(input int gap);
        int n;
        n = 0;
        while (n < CH * TAPS) begin
            @(negedge clk);
            weight_tvalid = ($urandom_range(99) >= gap);
            weight_tdata  = wbits[n];
            compare_value("weight_tready", 32'(weight_tready), 1);
            compare_value("image_tready", 32'(image_tready), 0);
            if (weight_tvalid && weight_tready) begin
                n++;
            end
        end
        @(negedge clk);
        weight_tvalid = 1'b0;
        compare_value("weight_tready", 32'(weight_tready), 0);   // falls after bit 150
    endtask

    task automatic send_image(input int row, input int gap);
        int n;
        n = 0;
        while (n < IMG * IMG) begin
            @(negedge clk);
            image_tvalid = ($urandom_range(99) >= gap);
            image_tdata  = img[n];
            start        = (row == 1) && (n >= 300) && (n < 310);   // edge while busy
            compare_value("weight_tready", 32'(weight_tready), 0);
            if (image_tvalid && image_tready) begin
                n++;
            end
        end
        @(negedge clk);
        image_tvalid = 1'b0;
        start        = 1'b0;
        compare_value("image_tready", 32'(image_tready), 0);   // no 785th pixel
    endtask

    task automatic run_case(input int row);
        build_case(row);
        result_cnt = 0;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        compare_value("weight_tready", 32'(weight_tready), 1);
        send_weights(cases[row].gap_pct);
        send_image(row, cases[row].gap_pct);
        wait (done_cnt == row + 1);
        @(negedge clk);
        compare_value("result_cnt", result_cnt, RESULTS);
        repeat (20) @(negedge clk);
        compare_value("done_cnt", done_cnt, row + 1);
    endtask

    always @(negedge clk) begin : result_monitor
        exp_word_t e;
        if (rstn && result_tvalid) begin
            if (exp_q.size() == 0) begin
                abort_run("result_tvalid went high with no result expected");
            end else begin
                e = exp_q.pop_front();
                compare_value("result_channel", 32'(result_channel), 32'(e.ch));
                compare_value("result_tdata", result_tdata, e.sum);
                result_cnt++;
            end
        end
        if (rstn && cnn_done) begin
            if (exp_q.size() != 0) begin
                abort_run("cnn_done pulsed before all results came out");
            end else begin
                done_cnt++;
            end
        end
    end

    initial begin
        repeat (16 + WATCHDOG_CYCLES) @(posedge clk);
        abort_run("watchdog expired before all cases finished");
    end

    initial begin
        void'($urandom(32'hdaa3_73cb));
        rstn          = 1'b0;
        start         = 1'b0;
        weight_tvalid = 1'b0;
        weight_tdata  = 1'b0;
        image_tvalid  = 1'b0;
        image_tdata   = '0;
        result_cnt    = 0;
        done_cnt      = 0;
        load_cases();
        repeat (16) @(negedge clk);
        rstn = 1'b1;
        repeat (10) begin   // quiet until the first start
            @(negedge clk);
            compare_value("image_tready", 32'(image_tready), 0);
            compare_value("weight_tready", 32'(weight_tready), 0);
            compare_value("result_tvalid", 32'(result_tvalid), 0);
            compare_value("cnn_done", 32'(cnn_done), 0);
        end
        for (int row = 0; row < N_ROWS; row++) begin
            run_case(row);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule
